// File: rtl/rv_pkg.sv
// RV32I subset only (word loads and stores, BEQ/BNE); programs must fit in 4 KB of instruction space
package rv_pkg;

	typedef logic [31:0] word_t;     // Data word
	typedef logic [4:0]  reg_idx_t;  // Register index
	typedef logic [11:0] pc_t;       // Instruction byte address
	typedef logic [10:0] dm_addr_t;  // Data memory word address
	typedef logic [3:0]  byte_en_t;  // One bit per byte lane

	// ALU operations
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	// Writeback source
	typedef enum logic [1:0] {
		WB_ALU,
		WB_LOAD,
		WB_IMM
	} wb_sel_e;

	// Operand source in ID
	typedef enum logic [1:0] {
		FWD_RF,
		FWD_EXE,
		FWD_MEM,
		FWD_WB
	} fwd_sel_e;

	localparam pc_t PC_STEP = 12'd4;  // No compressed instructions

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

	localparam logic [2:0] F3_ADD = 3'b000;  // Also BEQ
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;  // Also LW and SW
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam word_t NOP_INST = 32'h0000_0013;  // addi x0,x0,0

endpackage

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps
// Every branch is predicted not taken; the fetched word must be valid in the same cycle as inst_addr
module fetch_stage (
	input  logic          clk,
	input  logic          arst_n,
	input  rv_pkg::word_t inst,
	input  logic          front_stall,
	input  logic          if_id_flush,
	input  logic          redirect,
	input  rv_pkg::pc_t   branch_target,
	output rv_pkg::pc_t   inst_addr,
	output rv_pkg::word_t id_inst,
	output rv_pkg::pc_t   id_pc
);
	rv_pkg::pc_t pc;       // Fetch address
	rv_pkg::pc_t pc_next;

	// Redirect beats the load-use hold
	always_comb begin
		if (redirect)
			pc_next = branch_target;
		else if (front_stall)
			pc_next = pc;
		else
			pc_next = pc + rv_pkg::PC_STEP;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pc <= '0;
		else
			pc <= pc_next;
	end

	// IF/ID register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_inst <= rv_pkg::NOP_INST;
			id_pc   <= '0;
		end else if (if_id_flush) begin
			id_inst <= rv_pkg::NOP_INST;  // Kill the wrong-path word
			id_pc   <= pc;
		end else if (!front_stall) begin
			id_inst <= inst;
			id_pc   <= pc;
		end
	end

	assign inst_addr = pc;

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
// Unsupported opcodes decode as NOPs; branch and store operands are resolved here from forwarded data
module decode_stage (
	input  logic              clk,
	input  logic              arst_n,
	input  rv_pkg::word_t     id_inst,
	input  rv_pkg::pc_t       id_pc,
	input  logic              front_stall,
	input  logic              id_exe_flush,
	input  rv_pkg::fwd_sel_e  fwd_sel_a,
	input  rv_pkg::fwd_sel_e  fwd_sel_b,
	input  rv_pkg::word_t     exe_result,
	input  rv_pkg::word_t     mem_result,
	input  rv_pkg::word_t     wb_data,
	input  rv_pkg::reg_idx_t  wb_rd,
	input  logic              wb_wr_en,
	output rv_pkg::reg_idx_t  id_rs1,
	output rv_pkg::reg_idx_t  id_rs2,
	output rv_pkg::word_t     exe_op_a,
	output rv_pkg::word_t     exe_op_b,
	output rv_pkg::word_t     exe_store_data,
	output rv_pkg::word_t     exe_imm,
	output rv_pkg::pc_t       exe_pc,
	output rv_pkg::alu_op_e   exe_alu_op,
	output rv_pkg::reg_idx_t  exe_rd,
	output logic              exe_wr_en,
	output logic              exe_is_load,
	output logic              exe_is_store,
	output logic              exe_is_branch,
	output logic              exe_branch_ne,
	output rv_pkg::wb_sel_e   exe_wb_sel
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	rv_pkg::word_t imm_i;
	rv_pkg::word_t imm_s;
	rv_pkg::word_t imm_b;
	rv_pkg::word_t imm_u;
	rv_pkg::word_t imm;          // Selected immediate
	rv_pkg::alu_op_e alu_op;
	rv_pkg::wb_sel_e wb_sel;
	logic wr_en;
	logic is_load;
	logic is_store;
	logic is_branch;
	logic use_rs1;
	logic use_rs2;
	logic use_imm;               // Operand B from immediate
	rv_pkg::word_t rf [32];      // x0 is never written
	rv_pkg::word_t fwd_a;
	rv_pkg::word_t fwd_b;

	assign opcode = id_inst[6:0];
	assign funct3 = id_inst[14:12];
	assign funct7 = id_inst[31:25];

	assign imm_i = {{20{id_inst[31]}}, id_inst[31:20]};
	assign imm_s = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
	assign imm_b = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
		id_inst[11:8], 1'b0};
	assign imm_u = {id_inst[31:12], 12'b0};

	always_comb begin
		alu_op    = rv_pkg::ALU_ADD;
		wb_sel    = rv_pkg::WB_ALU;
		imm       = imm_i;
		wr_en     = 1'b0;
		is_load   = 1'b0;
		is_store  = 1'b0;
		is_branch = 1'b0;
		use_rs1   = 1'b0;
		use_rs2   = 1'b0;
		use_imm   = 1'b1;
		case (opcode)
			rv_pkg::OP_LUI: begin
				alu_op = rv_pkg::ALU_PASS_B;
				wb_sel = rv_pkg::WB_IMM;
				imm    = imm_u;
				wr_en  = 1'b1;
			end
			rv_pkg::OP_IMM, rv_pkg::OP_REG: begin
				wr_en   = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = (opcode == rv_pkg::OP_REG);
				use_imm = (opcode == rv_pkg::OP_IMM);
				case (funct3)
					rv_pkg::F3_SLT: alu_op = rv_pkg::ALU_SLT;
					rv_pkg::F3_XOR: alu_op = rv_pkg::ALU_XOR;
					rv_pkg::F3_OR:  alu_op = rv_pkg::ALU_OR;
					rv_pkg::F3_AND: alu_op = rv_pkg::ALU_AND;
					rv_pkg::F3_ADD: begin
						// SUB only in register form
						if (use_rs2 && funct7[5])
							alu_op = rv_pkg::ALU_SUB;
					end
					default: ;
				endcase
			end
			rv_pkg::OP_LOAD: begin
				wb_sel  = rv_pkg::WB_LOAD;
				wr_en   = 1'b1;
				is_load = 1'b1;
				use_rs1 = 1'b1;
			end
			rv_pkg::OP_STORE: begin
				imm      = imm_s;
				is_store = 1'b1;
				use_rs1  = 1'b1;
				use_rs2  = 1'b1;  // Store data
			end
			rv_pkg::OP_BRANCH: begin
				imm       = imm_b;
				is_branch = 1'b1;
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				use_imm   = 1'b0;
			end
			default: ;
		endcase
	end

	// Unused sources read as x0 so they never stall or forward
	assign id_rs1 = use_rs1 ? id_inst[19:15] : '0;
	assign id_rs2 = use_rs2 ? id_inst[24:20] : '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++)
				rf[i] <= '0;
		end else if (wb_wr_en && wb_rd != '0) begin
			rf[wb_rd] <= wb_data;
		end
	end

	function automatic rv_pkg::word_t pick_operand(input rv_pkg::fwd_sel_e sel,
			input rv_pkg::word_t rf_val, input rv_pkg::word_t from_exe,
			input rv_pkg::word_t from_mem, input rv_pkg::word_t from_wb);
		case (sel)
			rv_pkg::FWD_EXE: pick_operand = from_exe;
			rv_pkg::FWD_MEM: pick_operand = from_mem;
			rv_pkg::FWD_WB:  pick_operand = from_wb;  // Same-cycle RF write
			default:         pick_operand = rf_val;
		endcase
	endfunction

	assign fwd_a = pick_operand(fwd_sel_a, rf[id_rs1], exe_result, mem_result, wb_data);
	assign fwd_b = pick_operand(fwd_sel_b, rf[id_rs2], exe_result, mem_result, wb_data);

	// ID/EXE control
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exe_alu_op    <= rv_pkg::ALU_ADD;
			exe_wb_sel    <= rv_pkg::WB_ALU;
			exe_rd        <= '0;
			exe_wr_en     <= 1'b0;
			exe_is_load   <= 1'b0;
			exe_is_store  <= 1'b0;
			exe_is_branch <= 1'b0;
			exe_branch_ne <= 1'b0;
		end else if (id_exe_flush) begin
			// Also the load-use bubble
			exe_alu_op    <= rv_pkg::ALU_ADD;
			exe_wb_sel    <= rv_pkg::WB_ALU;
			exe_rd        <= '0;
			exe_wr_en     <= 1'b0;
			exe_is_load   <= 1'b0;
			exe_is_store  <= 1'b0;
			exe_is_branch <= 1'b0;
			exe_branch_ne <= 1'b0;
		end else if (!front_stall) begin
			exe_alu_op    <= alu_op;
			exe_wb_sel    <= wb_sel;
			exe_rd        <= id_inst[11:7];
			exe_wr_en     <= wr_en;
			exe_is_load   <= is_load;
			exe_is_store  <= is_store;
			exe_is_branch <= is_branch;
			exe_branch_ne <= (funct3 == rv_pkg::F3_BNE);
		end
	end

	// ID/EXE payload
	always_ff @(posedge clk) begin
		if (!front_stall) begin
			exe_op_a       <= fwd_a;
			exe_op_b       <= use_imm ? imm : fwd_b;
			exe_store_data <= fwd_b;
			exe_imm        <= imm;
			exe_pc         <= id_pc;  // Base for the branch target
		end
	end

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps
// Purely combinational; load data is never forwarded from EXE, the consumer stalls one cycle instead
module hazard_unit (
	input  rv_pkg::reg_idx_t  id_rs1,
	input  rv_pkg::reg_idx_t  id_rs2,
	input  rv_pkg::reg_idx_t  exe_rd,
	input  logic              exe_wr_en,
	input  logic              exe_is_load,
	input  rv_pkg::reg_idx_t  mem_rd,
	input  logic              mem_wr_en,
	input  rv_pkg::reg_idx_t  wb_rd,
	input  logic              wb_wr_en,
	input  logic              branch_taken,
	output rv_pkg::fwd_sel_e  fwd_sel_a,
	output rv_pkg::fwd_sel_e  fwd_sel_b,
	output logic              front_stall,
	output logic              if_id_flush,
	output logic              id_exe_flush,
	output logic              redirect
);
	logic load_use;

	// Youngest writer first
	function automatic rv_pkg::fwd_sel_e pick_source(input rv_pkg::reg_idx_t rs,
			input rv_pkg::reg_idx_t e_rd, input logic e_wr, input rv_pkg::reg_idx_t m_rd,
			input logic m_wr, input rv_pkg::reg_idx_t w_rd, input logic w_wr);
		if (rs == '0)
			pick_source = rv_pkg::FWD_RF;  // x0 stays zero
		else if (e_wr && e_rd == rs)
			pick_source = rv_pkg::FWD_EXE;
		else if (m_wr && m_rd == rs)
			pick_source = rv_pkg::FWD_MEM;
		else if (w_wr && w_rd == rs)
			pick_source = rv_pkg::FWD_WB;
		else
			pick_source = rv_pkg::FWD_RF;
	endfunction

	assign fwd_sel_a = pick_source(id_rs1, exe_rd, exe_wr_en, mem_rd, mem_wr_en, wb_rd, wb_wr_en);
	assign fwd_sel_b = pick_source(id_rs2, exe_rd, exe_wr_en, mem_rd, mem_wr_en, wb_rd, wb_wr_en);

	assign load_use = exe_is_load && exe_wr_en && exe_rd != '0
		&& (exe_rd == id_rs1 || exe_rd == id_rs2);

	assign front_stall  = load_use && !branch_taken;  // Flushed anyway on a taken branch
	assign if_id_flush  = branch_taken;
	assign id_exe_flush = branch_taken || load_use;  // Bubble into EXE
	assign redirect     = branch_taken;

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
// Word stores only, the low two address bits are ignored; addresses wrap at 8 KB of data memory
module execute_stage (
	input  logic              clk,
	input  logic              arst_n,
	input  rv_pkg::word_t     exe_op_a,
	input  rv_pkg::word_t     exe_op_b,
	input  rv_pkg::word_t     exe_store_data,
	input  rv_pkg::word_t     exe_imm,
	input  rv_pkg::pc_t       exe_pc,
	input  rv_pkg::alu_op_e   exe_alu_op,
	input  rv_pkg::reg_idx_t  exe_rd,
	input  logic              exe_wr_en,
	input  logic              exe_is_store,
	input  logic              exe_is_branch,
	input  logic              exe_branch_ne,
	input  rv_pkg::wb_sel_e   exe_wb_sel,
	output rv_pkg::word_t     exe_result,
	output logic              branch_taken,
	output rv_pkg::pc_t       branch_target,
	output rv_pkg::dm_addr_t  dm_addr,
	output rv_pkg::byte_en_t  dm_write,
	output rv_pkg::word_t     dm_wdata,
	output rv_pkg::reg_idx_t  mem_rd,
	output logic              mem_wr_en,
	output rv_pkg::wb_sel_e   mem_wb_sel,
	output rv_pkg::word_t     mem_alu,
	output rv_pkg::word_t     mem_imm
);
	rv_pkg::word_t alu_out;
	logic ops_equal;

	always_comb begin
		case (exe_alu_op)
			rv_pkg::ALU_SUB:    alu_out = exe_op_a - exe_op_b;
			rv_pkg::ALU_AND:    alu_out = exe_op_a & exe_op_b;
			rv_pkg::ALU_OR:     alu_out = exe_op_a | exe_op_b;
			rv_pkg::ALU_XOR:    alu_out = exe_op_a ^ exe_op_b;
			rv_pkg::ALU_SLT:    alu_out = {31'b0, $signed(exe_op_a) < $signed(exe_op_b)};
			rv_pkg::ALU_PASS_B: alu_out = exe_op_b;  // LUI
			default:            alu_out = exe_op_a + exe_op_b;
		endcase
	end

	// Value seen by a dependent instruction in ID
	assign exe_result = (exe_wb_sel == rv_pkg::WB_IMM) ? exe_imm : alu_out;

	// BEQ and BNE only
	assign ops_equal     = (exe_op_a == exe_op_b);
	assign branch_taken  = exe_is_branch && (ops_equal != exe_branch_ne);
	assign branch_target = exe_pc + exe_imm[11:0];

	// Core port of data memory, written at the end of this cycle
	assign dm_addr  = alu_out[12:2];
	assign dm_write = exe_is_store ? 4'b1111 : 4'b0000;
	assign dm_wdata = exe_store_data;

	// EXE/MEM control
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_rd     <= '0;
			mem_wr_en  <= 1'b0;
			mem_wb_sel <= rv_pkg::WB_ALU;
		end else begin
			mem_rd     <= exe_rd;
			mem_wr_en  <= exe_wr_en;
			mem_wb_sel <= exe_wb_sel;
		end
	end

	always_ff @(posedge clk) begin
		mem_alu <= alu_out;
		mem_imm <= exe_imm;
	end

endmodule

// File: rtl/memory_stage.sv
`timescale 1ns/1ps
// Memory contents are undefined after reset; on a same-word collision the core store wins the host write
module memory_stage (
	input  logic              clk,
	input  logic              arst_n,
	input  rv_pkg::dm_addr_t  dm_addr,
	input  rv_pkg::byte_en_t  dm_write,
	input  rv_pkg::word_t     dm_wdata,
	input  rv_pkg::reg_idx_t  mem_rd,
	input  logic              mem_wr_en,
	input  rv_pkg::wb_sel_e   mem_wb_sel,
	input  rv_pkg::word_t     mem_alu,
	input  rv_pkg::word_t     mem_imm,
	input  rv_pkg::byte_en_t  con_write,
	input  rv_pkg::dm_addr_t  con_addr,
	input  rv_pkg::word_t     con_in,
	output rv_pkg::word_t     mem_result,
	output rv_pkg::reg_idx_t  wb_rd,
	output logic              wb_wr_en,
	output rv_pkg::word_t     wb_data,
	output rv_pkg::word_t     con_out
);
	rv_pkg::word_t ram [2048];  // 8 KB
	rv_pkg::word_t dm_rdata;    // Load data, valid in MEM

	// Host lane first so the core lane lands last
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (con_write[i])
				ram[con_addr][8*i +: 8] <= con_in[8*i +: 8];
			if (dm_write[i])
				ram[dm_addr][8*i +: 8] <= dm_wdata[8*i +: 8];
		end
		dm_rdata <= ram[dm_addr];   // Old data on a same-edge write
		con_out  <= ram[con_addr];
	end

	// Also the MEM forwarding source
	always_comb begin
		case (mem_wb_sel)
			rv_pkg::WB_LOAD: mem_result = dm_rdata;
			rv_pkg::WB_IMM:  mem_result = mem_imm;
			default:         mem_result = mem_alu;
		endcase
	end

	// MEM/WB register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_rd    <= '0;
			wb_wr_en <= 1'b0;
		end else begin
			wb_rd    <= mem_rd;
			wb_wr_en <= mem_wr_en;
		end
	end

	always_ff @(posedge clk)
		wb_data <= mem_result;

endmodule

// File: rtl/rv_core.sv
`timescale 1ns/1ps
// Instruction port is combinational with no wait states; host and core must not write one word together
module rv_core (
	input  logic             clk,
	input  logic             arst_n,
	output rv_pkg::pc_t      inst_addr,
	input  rv_pkg::word_t    inst,
	input  rv_pkg::byte_en_t con_write,
	input  rv_pkg::dm_addr_t con_addr,
	input  rv_pkg::word_t    con_in,
	output rv_pkg::word_t    con_out
);
	// IF/ID and hazard control
	rv_pkg::word_t id_inst;
	rv_pkg::pc_t id_pc;
	logic front_stall;
	logic if_id_flush;
	logic id_exe_flush;
	logic redirect;
	logic branch_taken;
	rv_pkg::pc_t branch_target;
	rv_pkg::fwd_sel_e fwd_sel_a;
	rv_pkg::fwd_sel_e fwd_sel_b;
	rv_pkg::reg_idx_t id_rs1;
	rv_pkg::reg_idx_t id_rs2;

	// ID/EXE outputs
	rv_pkg::word_t exe_op_a;
	rv_pkg::word_t exe_op_b;
	rv_pkg::word_t exe_store_data;
	rv_pkg::word_t exe_imm;
	rv_pkg::pc_t exe_pc;
	rv_pkg::alu_op_e exe_alu_op;
	rv_pkg::reg_idx_t exe_rd;
	logic exe_wr_en;
	logic exe_is_load;
	logic exe_is_store;
	logic exe_is_branch;
	logic exe_branch_ne;
	rv_pkg::wb_sel_e exe_wb_sel;
	rv_pkg::word_t exe_result;  // Forwarded from EXE

	// Data memory core port and EXE/MEM
	rv_pkg::dm_addr_t dm_addr;
	rv_pkg::byte_en_t dm_write;
	rv_pkg::word_t dm_wdata;
	rv_pkg::reg_idx_t mem_rd;
	logic mem_wr_en;
	rv_pkg::wb_sel_e mem_wb_sel;
	rv_pkg::word_t mem_alu;
	rv_pkg::word_t mem_imm;
	rv_pkg::word_t mem_result;  // Forwarded from MEM

	// MEM/WB
	rv_pkg::reg_idx_t wb_rd;
	logic wb_wr_en;
	rv_pkg::word_t wb_data;

	fetch_stage u_fetch (
		.clk, .arst_n, .inst, .front_stall, .if_id_flush, .redirect, .branch_target,
		.inst_addr, .id_inst, .id_pc
	);

	decode_stage u_decode (
		.clk, .arst_n, .id_inst, .id_pc, .front_stall, .id_exe_flush,
		.fwd_sel_a, .fwd_sel_b, .exe_result, .mem_result, .wb_data, .wb_rd, .wb_wr_en,
		.id_rs1, .id_rs2, .exe_op_a, .exe_op_b, .exe_store_data, .exe_imm, .exe_pc,
		.exe_alu_op, .exe_rd, .exe_wr_en, .exe_is_load, .exe_is_store, .exe_is_branch,
		.exe_branch_ne, .exe_wb_sel
	);

	hazard_unit u_hazard (
		.id_rs1, .id_rs2, .exe_rd, .exe_wr_en, .exe_is_load, .mem_rd, .mem_wr_en,
		.wb_rd, .wb_wr_en, .branch_taken,
		.fwd_sel_a, .fwd_sel_b, .front_stall, .if_id_flush, .id_exe_flush, .redirect
	);

	execute_stage u_execute (
		.clk, .arst_n, .exe_op_a, .exe_op_b, .exe_store_data, .exe_imm, .exe_pc,
		.exe_alu_op, .exe_rd, .exe_wr_en, .exe_is_store, .exe_is_branch, .exe_branch_ne,
		.exe_wb_sel, .exe_result, .branch_taken, .branch_target, .dm_addr, .dm_write,
		.dm_wdata, .mem_rd, .mem_wr_en, .mem_wb_sel, .mem_alu, .mem_imm
	);

	memory_stage u_memory (
		.clk, .arst_n, .dm_addr, .dm_write, .dm_wdata, .mem_rd, .mem_wr_en, .mem_wb_sel,
		.mem_alu, .mem_imm, .con_write, .con_addr, .con_in,
		.mem_result, .wb_rd, .wb_wr_en, .wb_data, .con_out
	);

endmodule

// File: tb/rv_core_tb.sv
`timescale 1ns/1ps
// Needs tb/core_cases.txt under the run directory; last I line is the closing loop; max 8 preloads
module rv_core_tb;
	localparam int MAX_INST  = 1024;  // 4 KB of instruction space
	localparam int RESET_CYC = 10;

	logic             clk = 1'b0;
	logic             arst_n;
	rv_pkg::pc_t      inst_addr;
	rv_pkg::word_t    inst;
	rv_pkg::byte_en_t con_write;
	rv_pkg::dm_addr_t con_addr;
	rv_pkg::word_t    con_in;
	rv_pkg::word_t    con_out;

	rv_pkg::word_t    prog [MAX_INST];  // Program image
	rv_pkg::dm_addr_t pre_addr [$];     // Host preloads, in file order
	rv_pkg::byte_en_t pre_be [$];
	rv_pkg::word_t    pre_data [$];
	rv_pkg::dm_addr_t exp_addr [$];     // Expected memory words
	rv_pkg::word_t    exp_data [$];
	rv_pkg::dm_addr_t done_addr;
	rv_pkg::word_t    done_value;
	rv_pkg::pc_t      spin_addr;        // Final BEQ x0,x0,0
	int               inst_count;
	int               cycle_count;
	int               cycle_limit;
	int               wait_cycles;
	rv_pkg::word_t    got;

	rv_core uut (
		.clk, .arst_n, .inst_addr, .inst, .con_write, .con_addr, .con_in, .con_out
	);

	always #5 clk = ~clk;

	// No wait states on the instruction port
	assign inst = prog[inst_addr[11:2]];

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "run aborted");
	endtask

	task automatic compare_word(input string name, input string where,
			input rv_pkg::word_t actual, input rv_pkg::word_t expected);
		if (actual !== expected)
			abort_run($sformatf("[ERROR] %s %s: got %h, expected %h",
				name, where, actual, expected));
	endtask

	task automatic load_cases();
		int fd;
		int n;
		int i;
		logic [7:0] tag;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [8*128-1:0] skip;  // Rest of a comment line
		for (i = 0; i < MAX_INST; i++)
			prog[i] = rv_pkg::NOP_INST;  // Unfilled slots are NOPs
		inst_count = 0;
		fd = $fopen("tb/core_cases.txt", "r");
		if (fd == 0)
			abort_run("Cannot open tb/core_cases.txt");
		while ($fscanf(fd, " %c", tag) == 1) begin
			case (tag)
				"#": n = $fgets(skip, fd);
				"I": begin
					n = $fscanf(fd, "%h %h", f1, f2);  // Byte address, word
					if (n != 2)
						abort_run("Malformed I line in the case file");
					prog[f1[11:2]] = f2;
					spin_addr = f1[11:0];
					inst_count++;
				end
				"H": begin
					n = $fscanf(fd, "%h %h %h", f1, f2, f3);  // Word address, lanes, data
					if (n != 3)
						abort_run("Malformed H line in the case file");
					pre_addr.push_back(f1[10:0]);
					pre_be.push_back(f2[3:0]);
					pre_data.push_back(f3);
				end
				"E": begin
					n = $fscanf(fd, "%h %h", f1, f2);
					if (n != 2)
						abort_run("Malformed E line in the case file");
					exp_addr.push_back(f1[10:0]);
					exp_data.push_back(f2);
				end
				"D": begin
					n = $fscanf(fd, "%h %h", f1, f2);
					if (n != 2)
						abort_run("Malformed D line in the case file");
					done_addr  = f1[10:0];
					done_value = f2;
				end
				default: abort_run($sformatf("Unknown line tag '%c' in the case file", tag));
			endcase
		end
		$fclose(fd);
	endtask

	// One host write, entered and left 1 ns after a rising edge
	task automatic host_write(input rv_pkg::dm_addr_t addr, input rv_pkg::byte_en_t be,
			input rv_pkg::word_t data);
		con_addr  = addr;
		con_write = be;
		con_in    = data;
		@(posedge clk);
		#1;
		con_write = '0;
	endtask

	// Registered read, word is back one edge later
	task automatic read_word(input rv_pkg::dm_addr_t addr, output rv_pkg::word_t data);
		con_addr = addr;
		@(posedge clk);
		#1;
		data = con_out;
	endtask

	task automatic wait_for_done();
		rv_pkg::word_t value;
		value = '0;
		while (value !== done_value)
			read_word(done_addr, value);  // Bounded by the cycle counter
	endtask

	// Two wrong-path fetches behind each taken BEQ, so the loop repeats every 3 cycles
	task automatic check_fetch_loop();
		int k;
		rv_pkg::pc_t want;
		k = 0;
		while (inst_addr !== spin_addr && k < 3) begin
			@(posedge clk);
			#1;
			k++;
		end
		if (inst_addr !== spin_addr)
			abort_run("Fetch never came back to the closing branch loop");
		for (k = 1; k < 7; k++) begin
			@(posedge clk);
			#1;
			want = spin_addr + 4 * (k % 3);
			compare_word("inst_addr", $sformatf("in loop cycle %0d", k), inst_addr, want);
		end
	endtask

	// Counts only while the core runs
	always @(posedge clk) begin
		if (!arst_n) begin
			cycle_count = 0;
		end else begin
			cycle_count = cycle_count + 1;
			if (cycle_count > cycle_limit)
				abort_run($sformatf("Timeout, the program never finished within %0d cycles",
					cycle_limit));
		end
	end

	initial begin
		arst_n      = 1'b0;
		con_write   = '0;
		con_addr    = '0;
		con_in      = '0;
		cycle_count = 0;
		cycle_limit = 0;
		load_cases();
		cycle_limit = 20 * inst_count + 100;
		if (pre_addr.size() + 1 > RESET_CYC - 1)
			abort_run("Too many host preloads to fit inside reset");
		@(posedge clk);
		#1;
		foreach (pre_addr[i])
			host_write(pre_addr[i], pre_be[i], pre_data[i]);
		host_write(done_addr, 4'hf, '0);  // Clear stale done flag
		wait_cycles = RESET_CYC - 1 - pre_addr.size() - 1;
		repeat (wait_cycles) @(posedge clk);
		#1;
		arst_n = 1'b1;
		wait_for_done();
		check_fetch_loop();
		foreach (exp_addr[i]) begin
			read_word(exp_addr[i], got);
			compare_word("con_out", $sformatf("at address %h", exp_addr[i]), got, exp_data[i]);
		end
		$display("No errors");
		$finish;
	end

endmodule

// File: list.f
rtl/rv_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/rv_core.sv
tb/rv_core_tb.sv

// File: tb/core_cases.txt
# I byte_addr inst | H word_addr byte_en data | E word_addr data | D word_addr value
# All fields hex; data word N sits at byte address 4*N
# Dependent chain at distances 1, 2 and 3
I 000 123450B7
I 004 67808093
I 008 0F000113
I 00C 0020C1B3
I 010 40118233
I 014 002222B3
I 018 00328333
I 01C 10302023
I 020 10402223
I 024 10502423
I 028 10602623
# Load then immediate use
I 02C 11002383
I 030 00538413
I 034 10802A23
# Taken BEQ/BNE over shadow stores, then not-taken pair
I 038 00300493
I 03C 00948463
I 040 10902C23
I 044 00049463
I 048 10902E23
I 04C 00048463
I 050 12902023
I 054 00949463
I 058 12902223
# Writes to x0, then store x0
I 05C 7FF00013
I 060 ABCDE037
I 064 12002423
# Copy of the host byte-lane word
I 068 12C02503
I 06C 12A02823
# Two stores to one word
I 070 11100593
I 074 12B02A23
I 078 11158593
I 07C 12B02A23
# Done flag and spin
I 080 5A500613
I 084 12C02E23
I 088 00000063
H 044 f 10000001
H 046 f DEADBEEF
H 047 f CAFEF00D
H 048 f 55555555
H 04A f 77777777
H 04B f 11223344
H 04B 5 AABBCCDD
E 040 12345688
E 041 00000010
E 042 00000001
E 043 12345689
E 045 10000006
E 046 DEADBEEF
E 047 CAFEF00D
E 048 00000003
E 049 00000003
E 04A 00000000
E 04B 11BB33DD
E 04C 11BB33DD
E 04D 00000222
D 04F 000005A5
